/* hw/bch_bma_pkg.sv */
//------------------------------
// Shared types for the BCH BMA solver over GF(2^13)
// Field polynomial x^13+x^4+x^3+x+1, elements in polynomial basis
// Locator and syndrome vectors are sized at the ports through T
//------------------------------
`default_nettype none

package bch_bma_pkg;

    // Field
    localparam int GF_M = 13;

    typedef logic [GF_M-1:0] gf_elem_t;

    // x^13 term implied
    localparam gf_elem_t GF_POLY = 13'h001b;
    localparam gf_elem_t GF_ONE  = 13'h0001;

    // Locator degree
    typedef logic [4:0] deg_t;

    // Operand pair of one multiplier
    typedef struct packed {
        gf_elem_t a;
        gf_elem_t b;
    } mult_ops_t;

    //------------------------------
    // Sequencer
    //------------------------------
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        EXPAND,
        DELTA,
        UPDATE,
        DONE
    } bma_phase_t;

    typedef struct packed {
        bma_phase_t phase;
        logic [4:0] step;
        logic [4:0] iter;
        logic       last_step;
    } seq_ctrl_t;

endpackage

`default_nettype wire

/* hw/gf_mult.sv */
//------------------------------
// Combinational GF(2^13) multiplier
// Horner form, MSB of b first, one long XOR cone
//------------------------------
`default_nettype none

module gf_mult (
    input  bch_bma_pkg::mult_ops_t ops_i,
    output bch_bma_pkg::gf_elem_t  prod_o
);

    always_comb
    begin
        bch_bma_pkg::gf_elem_t acc;
        acc = '0;
        for (int i = bch_bma_pkg::GF_M - 1; i >= 0; i--)
        begin
            // Multiply running sum by x, fold x^13 back in
            if (acc[bch_bma_pkg::GF_M-1])
            begin
                acc = {acc[bch_bma_pkg::GF_M-2:0], 1'b0} ^ bch_bma_pkg::GF_POLY;
            end
            else
            begin
                acc = {acc[bch_bma_pkg::GF_M-2:0], 1'b0};
            end
            if (ops_i.b[i])
            begin
                acc = acc ^ ops_i.a;
            end
        end
        prod_o = acc;
    end

endmodule

`default_nettype wire

/* hw/bma_sequencer.sv */
//------------------------------
// Phase sequencer of the BMA solver, fixed schedule
// Valid for T from 2 to 15; start_i is dropped unless idle
// Run length is 1 + (T-1) + T*(ceil((T+1)/2) + T+1) + 1 cycles
//------------------------------
`default_nettype none

module bma_sequencer #(
    parameter int T = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    output bch_bma_pkg::seq_ctrl_t ctrl_o,
    output logic                   busy_o,
    output logic                   done_o
);

    // Two locator terms per discrepancy cycle
    localparam int DELTA_STEPS = (T + 2) / 2;

    localparam logic [4:0] EXPAND_LAST = 5'(T - 2);
    localparam logic [4:0] DELTA_LAST  = 5'(DELTA_STEPS - 1);
    localparam logic [4:0] UPDATE_LAST = 5'(T);
    localparam logic [4:0] ITER_LAST   = 5'(T - 1);

    bch_bma_pkg::bma_phase_t phase_q;
    logic [4:0]              step_q;
    logic [4:0]              iter_q;
    logic                    last_step;

    always_comb
    begin
        case (phase_q)
            bch_bma_pkg::LOAD,
            bch_bma_pkg::DONE:   last_step = 1'b1;
            bch_bma_pkg::EXPAND: last_step = (step_q == EXPAND_LAST);
            bch_bma_pkg::DELTA:  last_step = (step_q == DELTA_LAST);
            bch_bma_pkg::UPDATE: last_step = (step_q == UPDATE_LAST);
            default:             last_step = 1'b0;
        endcase
    end

    //------------------------------
    // Phase, step and iteration
    //------------------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            phase_q <= bch_bma_pkg::IDLE;
            step_q  <= '0;
            iter_q  <= '0;
        end
        else
        begin
            case (phase_q)
                bch_bma_pkg::IDLE:
                begin
                    if (start_i)
                    begin
                        phase_q <= bch_bma_pkg::LOAD;
                    end
                end
                bch_bma_pkg::LOAD:
                begin
                    phase_q <= bch_bma_pkg::EXPAND;
                end
                bch_bma_pkg::EXPAND:
                begin
                    if (last_step)
                    begin
                        phase_q <= bch_bma_pkg::DELTA;
                    end
                end
                bch_bma_pkg::DELTA:
                begin
                    if (last_step)
                    begin
                        phase_q <= bch_bma_pkg::UPDATE;
                    end
                end
                bch_bma_pkg::UPDATE:
                begin
                    if (last_step)
                    begin
                        phase_q <= (iter_q == ITER_LAST) ? bch_bma_pkg::DONE : bch_bma_pkg::DELTA;
                    end
                end
                default:
                begin
                    phase_q <= bch_bma_pkg::IDLE;
                end
            endcase

            if (last_step || phase_q == bch_bma_pkg::IDLE)
            begin
                step_q <= '0;
            end
            else
            begin
                step_q <= step_q + 5'd1;
            end

            if (phase_q == bch_bma_pkg::LOAD)
            begin
                iter_q <= '0;
            end
            else if (phase_q == bch_bma_pkg::UPDATE && last_step)
            begin
                iter_q <= iter_q + 5'd1;
            end
        end
    end

    assign ctrl_o = '{phase: phase_q, step: step_q, iter: iter_q, last_step: last_step};
    assign busy_o = (phase_q != bch_bma_pkg::IDLE);
    assign done_o = (phase_q == bch_bma_pkg::DONE);

endmodule

`default_nettype wire

/* hw/syndrome_bank.sv */
//------------------------------
// Syndrome storage for the BMA solver
// Odd syndromes are sampled every idle cycle, so the start cycle wins
// Even syndromes S2..S(2T-2) are built by squaring during EXPAND
//------------------------------
`default_nettype none

module syndrome_bank #(
    parameter int T = 8
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  bch_bma_pkg::seq_ctrl_t            ctrl_i,
    input  bch_bma_pkg::gf_elem_t [T-1:0]     syndromes_i,
    input  bch_bma_pkg::gf_elem_t             square_i,
    output bch_bma_pkg::mult_ops_t            expand_ops_o,
    output bch_bma_pkg::mult_ops_t            delta_ops1_o,
    output bch_bma_pkg::mult_ops_t            delta_ops2_o,
    output logic                              error_o
);

    // odd_q[k] = S(2k+1), even_q[j] = S(2j)
    bch_bma_pkg::gf_elem_t odd_q  [T];
    bch_bma_pkg::gf_elem_t even_q [1:T-1];

    bch_bma_pkg::gf_elem_t square_src;
    bch_bma_pkg::gf_elem_t odd_sel;
    bch_bma_pkg::gf_elem_t even_sel;
    logic                  any_nonzero;
    logic                  error_q;

    always_ff @(posedge clk)
    begin
        if (ctrl_i.phase == bch_bma_pkg::IDLE)
        begin
            for (int k = 0; k < T; k++)
            begin
                odd_q[k] <= syndromes_i[k];
            end
        end
        // Step s writes S(2s+2)
        if (ctrl_i.phase == bch_bma_pkg::EXPAND)
        begin
            for (int j = 1; j < T; j++)
            begin
                if (ctrl_i.step == 5'(j - 1))
                begin
                    even_q[j] <= square_i;
                end
            end
        end
    end

    always_comb
    begin
        any_nonzero = 1'b0;
        for (int k = 0; k < T; k++)
        begin
            any_nonzero = any_nonzero | (|odd_q[k]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            error_q <= 1'b0;
        end
        else if (ctrl_i.phase == bch_bma_pkg::LOAD)
        begin
            error_q <= any_nonzero;
        end
    end

    //------------------------------
    // Operand selection
    //------------------------------
    // Step s squares S(s+1), ascending so S(j) exists before S(2j)
    always_comb
    begin
        square_src = '0;
        for (int k = 0; k < T; k++)
        begin
            if (ctrl_i.step == 5'(2 * k))
            begin
                square_src = odd_q[k];
            end
        end
        for (int j = 1; j < T; j++)
        begin
            if (ctrl_i.step == 5'(2 * j - 1))
            begin
                square_src = even_q[j];
            end
        end
    end

    // Index iter - step; negative or zero even index gives no term
    always_comb
    begin
        odd_sel  = '0;
        even_sel = '0;
        for (int k = 0; k < T; k++)
        begin
            if ({1'b0, ctrl_i.iter} == {1'b0, ctrl_i.step} + 6'(k))
            begin
                odd_sel = odd_q[k];
            end
        end
        for (int j = 1; j < T; j++)
        begin
            if ({1'b0, ctrl_i.iter} == {1'b0, ctrl_i.step} + 6'(j))
            begin
                even_sel = even_q[j];
            end
        end
    end

    assign expand_ops_o = '{a: square_src, b: square_src};
    assign delta_ops1_o = '{a: '0, b: odd_sel};
    assign delta_ops2_o = '{a: '0, b: even_sel};
    assign error_o      = error_q;

endmodule

`default_nettype wire

/* hw/bma_core.sv */
//------------------------------
// Inverse-free BMA datapath, binary BCH form
// New locator = theta*sigma + delta*x*prev, committed at the last update step
// Only the b field of the syndrome operand structs is used
//------------------------------
`default_nettype none

module bma_core #(
    parameter int T = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  bch_bma_pkg::seq_ctrl_t        ctrl_i,
    input  bch_bma_pkg::mult_ops_t        expand_ops_i,
    input  bch_bma_pkg::mult_ops_t        delta_ops1_i,
    input  bch_bma_pkg::mult_ops_t        delta_ops2_i,
    input  bch_bma_pkg::gf_elem_t         prod1_i,
    input  bch_bma_pkg::gf_elem_t         prod2_i,
    output bch_bma_pkg::mult_ops_t        ops1_o,
    output bch_bma_pkg::mult_ops_t        ops2_o,
    output logic                          delta_nonzero_o,
    output bch_bma_pkg::deg_t             degree_o,
    output bch_bma_pkg::gf_elem_t [T:0]   locator_o
);

    bch_bma_pkg::gf_elem_t [T:0]   locator_q;
    bch_bma_pkg::gf_elem_t [T-1:0] prev_q;
    bch_bma_pkg::gf_elem_t [T-1:0] shadow_q;
    bch_bma_pkg::gf_elem_t         delta_q;
    bch_bma_pkg::gf_elem_t         theta_q;
    bch_bma_pkg::deg_t             degree_q;

    bch_bma_pkg::gf_elem_t coef;
    bch_bma_pkg::gf_elem_t loc_even;
    bch_bma_pkg::gf_elem_t loc_odd;
    bch_bma_pkg::gf_elem_t loc_term;
    bch_bma_pkg::gf_elem_t prev_term;

    assign coef = prod1_i ^ prod2_i;

    // Swap condition: delta nonzero and 2L <= 2r
    assign delta_nonzero_o = (|delta_q) && ({degree_q, 1'b0} <= {ctrl_i.iter, 1'b0});

    //------------------------------
    // Term selection
    //------------------------------
    always_comb
    begin
        loc_even  = '0;
        loc_odd   = '0;
        loc_term  = '0;
        prev_term = '0;
        for (int k = 0; k <= T; k++)
        begin
            if ({ctrl_i.step, 1'b0} == 6'(k))
            begin
                loc_even = locator_q[k];
            end
            if ({ctrl_i.step, 1'b1} == 6'(k))
            begin
                loc_odd = locator_q[k];
            end
            if (ctrl_i.step == 5'(k))
            begin
                loc_term = locator_q[k];
            end
        end
        // x*prev, so coefficient k takes prev[k-1]
        for (int k = 1; k <= T; k++)
        begin
            if (ctrl_i.step == 5'(k))
            begin
                prev_term = prev_q[k-1];
            end
        end
    end

    always_comb
    begin
        ops1_o = '0;
        ops2_o = '0;
        case (ctrl_i.phase)
            bch_bma_pkg::EXPAND:
            begin
                ops1_o = expand_ops_i;
            end
            bch_bma_pkg::DELTA:
            begin
                ops1_o = '{a: loc_even, b: delta_ops1_i.b};
                ops2_o = '{a: loc_odd,  b: delta_ops2_i.b};
            end
            bch_bma_pkg::UPDATE:
            begin
                ops1_o = '{a: loc_term,  b: theta_q};
                ops2_o = '{a: prev_term, b: delta_q};
            end
            default:
            begin
                ops1_o = '0;
            end
        endcase
    end

    //------------------------------
    // Result registers
    //------------------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            locator_q <= '0;
            degree_q  <= '0;
        end
        else if (ctrl_i.phase == bch_bma_pkg::LOAD)
        begin
            locator_q    <= '0;
            locator_q[0] <= bch_bma_pkg::GF_ONE;
            degree_q     <= '0;
        end
        else if (ctrl_i.phase == bch_bma_pkg::UPDATE && ctrl_i.last_step)
        begin
            locator_q <= {coef, shadow_q};
            if (delta_nonzero_o)
            begin
                degree_q <= bch_bma_pkg::deg_t'({ctrl_i.iter, 1'b1} - {1'b0, degree_q});
            end
        end
    end

    // Working registers
    always_ff @(posedge clk)
    begin
        case (ctrl_i.phase)
            bch_bma_pkg::LOAD:
            begin
                theta_q   <= bch_bma_pkg::GF_ONE;
                prev_q    <= '0;
                prev_q[0] <= bch_bma_pkg::GF_ONE;
            end
            bch_bma_pkg::DELTA:
            begin
                delta_q <= ((ctrl_i.step == 5'd0) ? '0 : delta_q) ^ coef;
            end
            bch_bma_pkg::UPDATE:
            begin
                for (int k = 0; k < T; k++)
                begin
                    if (ctrl_i.step == 5'(k))
                    begin
                        shadow_q[k] <= coef;
                    end
                end
                if (ctrl_i.last_step)
                begin
                    if (delta_nonzero_o)
                    begin
                        // prev becomes x*sigma, top term falls off
                        theta_q <= delta_q;
                        prev_q  <= locator_q[T-1:0] << bch_bma_pkg::GF_M;
                    end
                    else
                    begin
                        prev_q <= prev_q << (2 * bch_bma_pkg::GF_M);
                    end
                end
            end
            default:
            begin
                theta_q <= theta_q;
            end
        endcase
    end

    assign degree_o  = degree_q;
    assign locator_o = locator_q;

endmodule

`default_nettype wire

/* hw/bch_bma_top.sv */
//------------------------------
// BCH error-locator solver top, GF(2^13)
// One problem at a time, results hold until the next start_i
//------------------------------
`default_nettype none

module bch_bma_top #(
    parameter int T = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start_i,
    input  bch_bma_pkg::gf_elem_t [T-1:0] syndromes_i,
    output logic                        busy_o,
    output logic                        done_o,
    output logic                        error_o,
    output bch_bma_pkg::deg_t           degree_o,
    output bch_bma_pkg::gf_elem_t [T:0] locator_o
);

    bch_bma_pkg::seq_ctrl_t ctrl;
    bch_bma_pkg::mult_ops_t expand_ops;
    bch_bma_pkg::mult_ops_t delta_ops1;
    bch_bma_pkg::mult_ops_t delta_ops2;
    bch_bma_pkg::mult_ops_t ops1;
    bch_bma_pkg::mult_ops_t ops2;
    bch_bma_pkg::gf_elem_t  prod1;
    bch_bma_pkg::gf_elem_t  prod2;

    bma_sequencer #(.T(T)) seq_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (start_i),
        .ctrl_o  (ctrl),
        .busy_o  (busy_o),
        .done_o  (done_o)
    );

    syndrome_bank #(.T(T)) synd_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl_i       (ctrl),
        .syndromes_i  (syndromes_i),
        .square_i     (prod1),
        .expand_ops_o (expand_ops),
        .delta_ops1_o (delta_ops1),
        .delta_ops2_o (delta_ops2),
        .error_o      (error_o)
    );

    // Swap decision stays inside the core
    bma_core #(.T(T)) core_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .ctrl_i          (ctrl),
        .expand_ops_i    (expand_ops),
        .delta_ops1_i    (delta_ops1),
        .delta_ops2_i    (delta_ops2),
        .prod1_i         (prod1),
        .prod2_i         (prod2),
        .ops1_o          (ops1),
        .ops2_o          (ops2),
        .delta_nonzero_o (),
        .degree_o        (degree_o),
        .locator_o       (locator_o)
    );

    gf_mult mult1_i (
        .ops_i  (ops1),
        .prod_o (prod1)
    );

    gf_mult mult2_i (
        .ops_i  (ops2),
        .prod_o (prod2)
    );

endmodule

`default_nettype wire

/* sim/bma_checker.sv */
//------------------------------
// Result monitor for the BCH BMA solver
// Latches the expected positions when a start is accepted
// Idle outputs are checked from reset to the first start
//------------------------------
`default_nettype none

module bma_checker #(
    parameter int T = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start_i,
    input  logic                          busy_i,
    input  logic                          done_i,
    input  logic                          error_i,
    input  bch_bma_pkg::deg_t             degree_i,
    input  bch_bma_pkg::gf_elem_t [T:0]   locator_i,
    input  bch_bma_pkg::deg_t             exp_count_i,
    input  bch_bma_pkg::gf_elem_t [T-1:0] exp_pos_i,
    output int                            pass_count_o,
    output int                            fail_count_o,
    output int                            open_errs_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // Load, expand, T iterations of delta and update, done
    localparam int LATENCY     = 1 + (T - 1) + T * ((T + 2) / 2 + T + 1) + 1;
    localparam int FIELD_ORDER = 8191;
    localparam bch_bma_pkg::gf_elem_t FIELD_POLY = 13'h001b;

    int                            cycle_count;
    int                            start_cycle;
    int                            test_num;
    int                            errs;
    logic                          in_flight;
    logic                          started;
    bch_bma_pkg::deg_t             run_count;
    bch_bma_pkg::gf_elem_t [T-1:0] run_pos;

    // Errors not yet closed by a finished test
    assign open_errs_o = errs;

    function automatic bch_bma_pkg::gf_elem_t field_mul(bch_bma_pkg::gf_elem_t a,
                                                        bch_bma_pkg::gf_elem_t b);
        bch_bma_pkg::gf_elem_t p;
        bch_bma_pkg::gf_elem_t x;
        p = '0;
        x = a;
        for (int i = 0; i < 13; i++)
        begin
            if (b[i])
            begin
                p = p ^ x;
            end
            x = x[12] ? ({x[11:0], 1'b0} ^ FIELD_POLY) : {x[11:0], 1'b0};
        end
        return p;
    endfunction

    function automatic bch_bma_pkg::gf_elem_t field_pow(int e);
        bch_bma_pkg::gf_elem_t r;
        bch_bma_pkg::gf_elem_t base;
        int                    k;
        r    = 13'h0001;
        base = 13'h0002;
        k    = e;
        while (k > 0)
        begin
            if (k[0])
            begin
                r = field_mul(r, base);
            end
            base = field_mul(base, base);
            k    = k >> 1;
        end
        return r;
    endfunction

    // Horner, highest coefficient first
    function automatic bch_bma_pkg::gf_elem_t eval_locator(bch_bma_pkg::gf_elem_t x);
        bch_bma_pkg::gf_elem_t acc;
        acc = '0;
        for (int k = T; k >= 0; k--)
        begin
            acc = field_mul(acc, x) ^ locator_i[k];
        end
        return acc;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            errs++;
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic finish_test(input string what);
        if (errs == 0)
        begin
            pass_count_o++;
            $display("test %0d, %s: passed", test_num, what);
        end
        else
        begin
            fail_count_o++;
            $display("test %0d, %s: failed with %0d errors", test_num, what, errs);
        end
        test_num++;
        errs = 0;
    endtask

    task automatic check_idle_outputs();
        check_value("done_o", done_i, 0);
        check_value("error_o", error_i, 0);
        check_value("degree_o", degree_i, 0);
        for (int k = 0; k <= T; k++)
        begin
            check_value($sformatf("locator_o[%0d]", k), locator_i[k], 0);
        end
    endtask

    task automatic check_result();
        bch_bma_pkg::gf_elem_t root;
        check_value("done_o latency", cycle_count - start_cycle, LATENCY);
        check_value("error_o", error_i, run_count != 0);
        check_value("degree_o", degree_i, run_count);
        if (locator_i[0] == '0)
        begin
            errs++;
            $display("FAILED locator_o[0]: got 0x0 expected a nonzero value");
        end
        for (int k = 1; k <= T; k++)
        begin
            if (k > int'(run_count))
            begin
                check_value($sformatf("locator_o[%0d]", k), locator_i[k], 0);
            end
        end
        // Roots sit at alpha^-pos
        for (int i = 0; i < int'(run_count); i++)
        begin
            root = field_pow((FIELD_ORDER - int'(run_pos[i])) % FIELD_ORDER);
            check_value($sformatf("locator_o at alpha^-%0d", run_pos[i]),
                        eval_locator(root), 0);
        end
    endtask

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            cycle_count  = 0;
            test_num     = 0;
            errs         = 0;
            in_flight    = 1'b0;
            started      = 1'b0;
            pass_count_o = 0;
            fail_count_o = 0;
        end
        else
        begin
            cycle_count++;
            // Busy from the cycle after an accepted start up to done
            check_value("busy_o", busy_i, in_flight);
            if (!started && !start_i)
            begin
                check_idle_outputs();
            end
            if (start_i && !busy_i)
            begin
                if (!started)
                begin
                    started = 1'b1;
                    finish_test("state after reset");
                end
                in_flight   = 1'b1;
                start_cycle = cycle_count;
                run_count   = exp_count_i;
                run_pos     = exp_pos_i;
            end
            if (done_i)
            begin
                if (in_flight)
                begin
                    check_result();
                    in_flight = 1'b0;
                    finish_test($sformatf("run with %0d errors", run_count));
                end
                else
                begin
                    errs++;
                    $display("done_o pulsed while no run was in flight");
                end
            end
        end
    end

endmodule

`default_nettype wire

/* sim/tb_bch_bma.sv */
//------------------------------
// Testbench for the BCH BMA solver, T = 8
// Error positions 0..8190 from a fixed-seed LCG
// Odd syndromes come from a GF(2^13) model kept here
//------------------------------
`default_nettype none

module tb_bch_bma;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int T           = 8;
    localparam int CLK_PERIOD  = 20;
    localparam int RANDOM_RUNS = 16;
    // Zero-syndrome run, random runs, overlapped start run
    localparam int RUNS        = RANDOM_RUNS + 2;
    localparam int RUN_CYCLES  = 121;
    localparam int WATCHDOG_CYCLES = RUNS * (RUN_CYCLES + 20) + 100;
    localparam int FIELD_ORDER = 8191;
    // x^13 + x^4 + x^3 + x + 1, top term implied
    localparam bch_bma_pkg::gf_elem_t FIELD_POLY = 13'h001b;

    logic                              clk;
    logic                              rst_n;
    logic                              start;
    bch_bma_pkg::gf_elem_t [T-1:0]     syndromes;
    logic                              busy;
    logic                              done;
    logic                              error;
    bch_bma_pkg::deg_t                 degree;
    bch_bma_pkg::gf_elem_t [T:0]       locator;

    bch_bma_pkg::deg_t                 exp_count;
    bch_bma_pkg::gf_elem_t [T-1:0]     exp_pos;
    int                                pass_count;
    int                                fail_count;
    int                                open_errs;
    int                                tb_errors;
    logic [31:0]                       lcg_state;

    // Current pattern
    bch_bma_pkg::deg_t                 pat_count;
    bch_bma_pkg::gf_elem_t [T-1:0]     pat_pos;
    bch_bma_pkg::gf_elem_t [T-1:0]     pat_synd;

    bch_bma_top #(.T(T)) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start),
        .syndromes_i (syndromes),
        .busy_o      (busy),
        .done_o      (done),
        .error_o     (error),
        .degree_o    (degree),
        .locator_o   (locator)
    );

    bma_checker #(.T(T)) chk_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start),
        .busy_i       (busy),
        .done_i       (done),
        .error_i      (error),
        .degree_i     (degree),
        .locator_i    (locator),
        .exp_count_i  (exp_count),
        .exp_pos_i    (exp_pos),
        .pass_count_o (pass_count),
        .fail_count_o (fail_count),
        .open_errs_o  (open_errs)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //------------------------------
    // GF model and random source
    //------------------------------
    function automatic bch_bma_pkg::gf_elem_t field_mul(bch_bma_pkg::gf_elem_t a,
                                                        bch_bma_pkg::gf_elem_t b);
        bch_bma_pkg::gf_elem_t p;
        bch_bma_pkg::gf_elem_t x;
        p = '0;
        x = a;
        // LSB of b first, a doubles each step
        for (int i = 0; i < 13; i++)
        begin
            if (b[i])
            begin
                p = p ^ x;
            end
            x = x[12] ? ({x[11:0], 1'b0} ^ FIELD_POLY) : {x[11:0], 1'b0};
        end
        return p;
    endfunction

    function automatic bch_bma_pkg::gf_elem_t field_pow(int e);
        bch_bma_pkg::gf_elem_t r;
        bch_bma_pkg::gf_elem_t base;
        int                    k;
        r    = 13'h0001;
        base = 13'h0002;
        k    = e;
        while (k > 0)
        begin
            if (k[0])
            begin
                r = field_mul(r, base);
            end
            base = field_mul(base, base);
            k    = k >> 1;
        end
        return r;
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Distinct positions, then S(2j+1) = sum of alpha^((2j+1)*pos)
    task automatic make_pattern(input int n);
        logic [31:0]           r;
        int                    cand;
        logic                  dup;
        bch_bma_pkg::gf_elem_t s;
        pat_pos   = '0;
        pat_count = bch_bma_pkg::deg_t'(n);
        for (int i = 0; i < n; i++)
        begin
            do
            begin
                r    = lcg_next();
                cand = int'((r >> 8) % FIELD_ORDER);
                dup  = 1'b0;
                for (int m = 0; m < i; m++)
                begin
                    if (int'(pat_pos[m]) == cand)
                    begin
                        dup = 1'b1;
                    end
                end
            end
            while (dup);
            pat_pos[i] = bch_bma_pkg::gf_elem_t'(cand);
        end
        for (int j = 0; j < T; j++)
        begin
            s = '0;
            for (int i = 0; i < n; i++)
            begin
                s = s ^ field_pow(((2 * j + 1) * int'(pat_pos[i])) % FIELD_ORDER);
            end
            pat_synd[j] = s;
        end
    endtask

    //------------------------------
    // Drivers
    //------------------------------
    // Called on a rising edge; start is high for the following cycle
    task automatic launch(input logic update_expected);
        start     <= 1'b1;
        syndromes <= pat_synd;
        if (update_expected)
        begin
            exp_count <= pat_count;
            exp_pos   <= pat_pos;
        end
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        do
        begin
            @(posedge clk);
            cycles++;
        end
        while (done !== 1'b1 && cycles < 2 * RUN_CYCLES);
        if (done !== 1'b1)
        begin
            tb_errors++;
            $display("no done_o within %0d cycles of the start pulse", 2 * RUN_CYCLES);
        end
    endtask

    initial
    begin
        rst_n     = 1'b0;
        start     = 1'b0;
        syndromes = '0;
        exp_count = '0;
        exp_pos   = '0;
        tb_errors = 0;
        lcg_state = 32'h71bd;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);

        // No errors at all
        make_pattern(0);
        launch(1'b1);
        wait_done();

        // First half with idle gaps, second half back to back
        for (int i = 0; i < RANDOM_RUNS; i++)
        begin
            make_pattern((i % T) + 1);
            launch(1'b1);
            wait_done();
            if (i < RANDOM_RUNS / 2)
            begin
                repeat (3) @(posedge clk);
            end
        end

        // Second start while busy must be dropped
        make_pattern(3);
        launch(1'b1);
        repeat (5) @(posedge clk);
        make_pattern(6);
        launch(1'b0);
        wait_done();

        repeat (3) @(posedge clk);
        @(negedge clk);
        $display("runs checked: %0d passed, %0d failed, %0d testbench errors",
                 pass_count, fail_count, tb_errors);
        if (pass_count + fail_count != RUNS + 1)
        begin
            $display("checker reported %0d results instead of %0d",
                     pass_count + fail_count, RUNS + 1);
        end
        if (open_errs != 0)
        begin
            $display("checker saw %0d errors after the last finished run", open_errs);
        end
        if (fail_count == 0 && tb_errors == 0 && open_errs == 0 && pass_count == RUNS + 1)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before all runs finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* bch_bma_top.f */
hw/bch_bma_pkg.sv
hw/gf_mult.sv
hw/bma_sequencer.sv
hw/syndrome_bank.sv
hw/bma_core.sv
hw/bch_bma_top.sv
sim/bma_checker.sv
sim/tb_bch_bma.sv
